/* rtl/ibuf_pkg.sv */
// shared widths and types; lines are 16 bytes, RESET_PC must be line aligned
package ibuf_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    // virtual pc width
    localparam int PC_WIDTH = 32;
    // one icache line per buffer entry
    localparam int LINE_BYTES = 16;
    localparam int HW_PER_LINE = LINE_BYTES / 2;
    localparam int CAUSE_WIDTH = 5;
    // byte offset bits inside a line
    localparam int LINE_OFF_WIDTH = $clog2(LINE_BYTES);
    // parcel index bits inside a line
    localparam int HW_IDX_WIDTH = $clog2(HW_PER_LINE);

    localparam logic [PC_WIDTH-1:0] RESET_PC = '0;

    // ----------------------------------------
    // types
    // ----------------------------------------
    // one 16-bit instruction parcel
    typedef logic [15:0] halfword_t;

    // one buffered line, 166 bits
    typedef struct packed {
        halfword_t [HW_PER_LINE-1:0] hw;
        // line-aligned fetch address
        logic [PC_WIDTH-1:0]         tag;
        logic                        excp;
        logic [CAUSE_WIDTH-1:0]      cause;
    } line_t;

    // one decode slot, 104 bits
    typedef struct packed {
        logic                   valid;
        logic [PC_WIDTH-1:0]    pc;
        logic [PC_WIDTH-1:0]    next_pc;
        // compressed words zero extended
        logic [31:0]            instr;
        // full 32-bit length
        logic                   is_rv;
        logic                   excp;
        logic [CAUSE_WIDTH-1:0] cause;
    } slot_t;

    // instructions taken by decode this cycle
    typedef enum logic [1:0] {
        ISSUE_NONE,
        ISSUE_ONE,
        ISSUE_TWO
    } issue_e;

endpackage

/* rtl/ibuf_fill.sv */
// fill side; lines are filled strictly in sequence, strobes while fetch_req_o is low are dropped
module ibuf_fill #(
    parameter int NUM_LINES = 2
) (
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic                                       flush_i,
    input  logic [ibuf_pkg::PC_WIDTH-1:0]              flush_pc_i,
    input  logic                                       fill_valid_i,
    input  ibuf_pkg::halfword_t [ibuf_pkg::HW_PER_LINE-1:0] fill_data_i,
    input  logic                                       fill_excp_i,
    input  logic [ibuf_pkg::CAUSE_WIDTH-1:0]           fill_cause_i,
    input  logic [NUM_LINES-1:0]                       line_valid_i,
    output logic [NUM_LINES-1:0]                       write_en_o,
    output ibuf_pkg::line_t                            write_line_o,
    output logic                                       fetch_req_o,
    output logic [ibuf_pkg::PC_WIDTH-1:0]              fetch_pc_o
);
    localparam int LN_W = $clog2(NUM_LINES);
    localparam int PCW = ibuf_pkg::PC_WIDTH;
    localparam int OFFW = ibuf_pkg::LINE_OFF_WIDTH;

    logic [LN_W-1:0] push_ptr_q;
    logic [PCW-1:0]  fetch_pc_q;
    logic            accept;

    // request while the push slot is drained
    assign fetch_req_o = ~line_valid_i[push_ptr_q];
    assign fetch_pc_o = fetch_pc_q;
    assign accept = fill_valid_i & fetch_req_o;

    // tag is the fetch address, already line aligned
    assign write_line_o.hw = fill_data_i;
    assign write_line_o.tag = fetch_pc_q;
    assign write_line_o.excp = fill_excp_i;
    assign write_line_o.cause = fill_cause_i;

    // one-hot write of the push line
    always_comb begin
        write_en_o = '0;
        write_en_o[push_ptr_q] = accept;
    end

    // ----------------------------------------
    // push pointer and fetch address
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            push_ptr_q <= '0;
            fetch_pc_q <= ibuf_pkg::RESET_PC;
        end else if (flush_i) begin
            // restart at line 0, aligned flush target
            push_ptr_q <= '0;
            fetch_pc_q <= {flush_pc_i[PCW-1:OFFW], {OFFW{1'b0}}};
        end else if (accept) begin
            push_ptr_q <= push_ptr_q + 1'b1;
            fetch_pc_q <= fetch_pc_q + PCW'(ibuf_pkg::LINE_BYTES);
        end
    end

endmodule

/* rtl/ibuf_line.sv */
// one buffer line; a write in the same cycle as a release keeps the line valid
module ibuf_line (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             flush_i,
    input  logic                             write_en_i,
    input  ibuf_pkg::line_t                  write_line_i,
    input  logic                             release_i,
    output ibuf_pkg::line_t                  line_o,
    output logic                             valid_o,
    output logic [ibuf_pkg::HW_PER_LINE-1:0] full_len_o
);
    ibuf_pkg::line_t line_q;
    logic            valid_q;

    // ----------------------------------------
    // storage
    // ----------------------------------------
    // parcels, tag and exception
    always_ff @(posedge clk) begin
        if (write_en_i) begin
            line_q <= write_line_i;
        end
    end

    // valid bit, flush drops everything
    always_ff @(posedge clk) begin
        if (reset || flush_i) begin
            valid_q <= 1'b0;
        end else if (write_en_i) begin
            valid_q <= 1'b1;
        end else if (release_i) begin
            // pop pointer has moved past this line
            valid_q <= 1'b0;
        end
    end

    assign line_o = line_q;
    assign valid_o = valid_q;

    // ----------------------------------------
    // length flags
    // ----------------------------------------
    // low bits 11 mark a 32-bit parcel start
    always_comb begin
        for (int i = 0; i < ibuf_pkg::HW_PER_LINE; i++) begin
            full_len_o[i] = &line_q.hw[i][1:0];
        end
    end

endmodule

/* rtl/ibuf_extract.sv */
// slot extraction; the four parcels after the pop pointer never wrap back to its own line
module ibuf_extract #(
    parameter int NUM_LINES = 2,
    localparam int PTR_W = $clog2(NUM_LINES) + ibuf_pkg::HW_IDX_WIDTH
) (
    input  logic [PTR_W-1:0]                                    pop_ptr_i,
    input  logic [ibuf_pkg::PC_WIDTH-1:0]                       pc_i,
    input  ibuf_pkg::line_t [NUM_LINES-1:0]                     lines_i,
    input  logic [NUM_LINES-1:0]                                valid_i,
    input  logic [NUM_LINES-1:0][ibuf_pkg::HW_PER_LINE-1:0]     full_len_i,
    output ibuf_pkg::slot_t                                     slot_first_o,
    output ibuf_pkg::slot_t                                     slot_second_o
);
    localparam int LN_W = $clog2(NUM_LINES);
    localparam int HW_W = ibuf_pkg::HW_IDX_WIDTH;
    localparam int PCW = ibuf_pkg::PC_WIDTH;

    // parcels in pointer order, with their line attributes
    ibuf_pkg::halfword_t              hw [4];
    logic [3:0]                       hw_vld;
    logic [3:0]                       hw_full;
    logic [3:0]                       hw_excp;
    logic [ibuf_pkg::CAUSE_WIDTH-1:0] hw_cause [4];

    // second slot start, 1 or 2 parcels in
    logic [1:0]     s2;
    logic           first_rv;
    logic           second_rv;
    logic [PCW-1:0] first_next;

    // ----------------------------------------
    // gather parcels from the pop pointer
    // ----------------------------------------
    always_comb begin
        logic [PTR_W-1:0] p;
        logic [LN_W-1:0]  ln;
        logic [HW_W-1:0]  hx;
        for (int k = 0; k < 4; k++) begin
            // wraps around the ring of lines
            p = pop_ptr_i + PTR_W'(k);
            ln = p[PTR_W-1:HW_W];
            hx = p[HW_W-1:0];
            hw[k] = lines_i[ln].hw[hx];
            hw_vld[k] = valid_i[ln];
            hw_full[k] = full_len_i[ln][hx];
            hw_excp[k] = lines_i[ln].excp;
            hw_cause[k] = lines_i[ln].cause;
        end
    end

    // ----------------------------------------
    // first slot
    // ----------------------------------------
    assign first_rv = hw_full[0];
    assign first_next = pc_i + (first_rv ? PCW'(4) : PCW'(2));

    always_comb begin
        // a 32-bit word needs its upper parcel too
        slot_first_o.valid = hw_vld[0] & (~first_rv | hw_vld[1]);
        slot_first_o.pc = pc_i;
        slot_first_o.next_pc = first_next;
        slot_first_o.instr = first_rv ? {hw[1], hw[0]} : {16'h0000, hw[0]};
        slot_first_o.is_rv = first_rv;
        // first excepting line wins
        slot_first_o.excp = hw_excp[0] | (first_rv & hw_excp[1]);
        slot_first_o.cause = hw_excp[0] ? hw_cause[0] : hw_cause[1];
    end

    // ----------------------------------------
    // second slot
    // ----------------------------------------
    assign s2 = first_rv ? 2'd2 : 2'd1;
    assign second_rv = hw_full[s2];

    always_comb begin
        // never valid without the first
        slot_second_o.valid = slot_first_o.valid & hw_vld[s2]
                            & (~second_rv | hw_vld[s2 + 2'd1]);
        slot_second_o.pc = first_next;
        slot_second_o.next_pc = first_next + (second_rv ? PCW'(4) : PCW'(2));
        if (second_rv) begin
            slot_second_o.instr = {hw[s2 + 2'd1], hw[s2]};
        end else begin
            slot_second_o.instr = {16'h0000, hw[s2]};
        end
        slot_second_o.is_rv = second_rv;
        slot_second_o.excp = hw_excp[s2] | (second_rv & hw_excp[s2 + 2'd1]);
        if (hw_excp[s2]) begin
            slot_second_o.cause = hw_cause[s2];
        end else begin
            // upper parcel sits in the next line
            slot_second_o.cause = hw_cause[s2 + 2'd1];
        end
    end

endmodule

/* rtl/ibuf_pop.sv */
// pop side; at most four parcels leave per cycle so only one line is released at a time
module ibuf_pop #(
    parameter int NUM_LINES = 2,
    localparam int PTR_W = $clog2(NUM_LINES) + ibuf_pkg::HW_IDX_WIDTH
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          flush_i,
    input  logic [ibuf_pkg::PC_WIDTH-1:0] flush_pc_i,
    input  logic                          single_rdy_i,
    input  logic                          double_rdy_i,
    input  ibuf_pkg::slot_t               slot_first_i,
    input  ibuf_pkg::slot_t               slot_second_i,
    output logic [PTR_W-1:0]              pop_ptr_o,
    output logic [ibuf_pkg::PC_WIDTH-1:0] pc_o,
    output logic [NUM_LINES-1:0]          release_o
);
    localparam int LN_W = $clog2(NUM_LINES);
    localparam int HW_W = ibuf_pkg::HW_IDX_WIDTH;
    localparam int PCW = ibuf_pkg::PC_WIDTH;
    localparam int OFFW = ibuf_pkg::LINE_OFF_WIDTH;

    ibuf_pkg::issue_e issue;
    // parcels per instruction and per issue
    logic [2:0]       len_first;
    logic [2:0]       len_second;
    logic [2:0]       step;
    logic [PTR_W-1:0] ptr_q;
    logic [PTR_W-1:0] ptr_next;
    logic [PCW-1:0]   pc_q;
    logic [PCW-1:0]   pc_next;
    logic [LN_W-1:0]  cur_line;
    logic [LN_W-1:0]  next_line;

    // ----------------------------------------
    // issue decision
    // ----------------------------------------
    always_comb begin
        if (double_rdy_i && slot_second_i.valid) begin
            issue = ibuf_pkg::ISSUE_TWO;
        end else if ((single_rdy_i || double_rdy_i) && slot_first_i.valid) begin
            issue = ibuf_pkg::ISSUE_ONE;
        end else begin
            issue = ibuf_pkg::ISSUE_NONE;
        end
    end

    assign len_first = slot_first_i.is_rv ? 3'd2 : 3'd1;
    assign len_second = slot_second_i.is_rv ? 3'd2 : 3'd1;

    // pc follows the last issued slot
    always_comb begin
        case (issue)
            ibuf_pkg::ISSUE_ONE: begin
                step = len_first;
                pc_next = slot_first_i.next_pc;
            end
            ibuf_pkg::ISSUE_TWO: begin
                step = len_first + len_second;
                pc_next = slot_second_i.next_pc;
            end
            default: begin
                step = 3'd0;
                pc_next = pc_q;
            end
        endcase
    end

    assign ptr_next = ptr_q + PTR_W'(step);

    // ----------------------------------------
    // line release
    // ----------------------------------------
    assign cur_line = ptr_q[PTR_W-1:HW_W];
    assign next_line = ptr_next[PTR_W-1:HW_W];

    always_comb begin
        release_o = '0;
        release_o[cur_line] = (cur_line != next_line);
    end

    // pointer restarts at line 0 plus the pc parcel offset
    always_ff @(posedge clk) begin
        if (reset) begin
            ptr_q <= PTR_W'(ibuf_pkg::RESET_PC[OFFW-1:1]);
            pc_q <= ibuf_pkg::RESET_PC;
        end else if (flush_i) begin
            ptr_q <= PTR_W'(flush_pc_i[OFFW-1:1]);
            pc_q <= flush_pc_i;
        end else begin
            ptr_q <= ptr_next;
            pc_q <= pc_next;
        end
    end

    assign pop_ptr_o = ptr_q;
    assign pc_o = pc_q;

endmodule

/* rtl/ibuf_top.sv */
// instruction buffer top; NUM_LINES must be a power of two and at least 2
module ibuf_top #(
    parameter int NUM_LINES = 2
) (
    input  logic                                            clk,
    input  logic                                            reset,
    input  logic                                            flush_i,
    input  logic [ibuf_pkg::PC_WIDTH-1:0]                   flush_pc_i,
    input  logic                                            fill_valid_i,
    input  ibuf_pkg::halfword_t [ibuf_pkg::HW_PER_LINE-1:0] fill_data_i,
    input  logic                                            fill_excp_i,
    input  logic [ibuf_pkg::CAUSE_WIDTH-1:0]                fill_cause_i,
    input  logic                                            single_rdy_i,
    input  logic                                            double_rdy_i,
    output logic                                            fetch_req_o,
    output logic [ibuf_pkg::PC_WIDTH-1:0]                   fetch_pc_o,
    output ibuf_pkg::slot_t                                 slot_first_o,
    output ibuf_pkg::slot_t                                 slot_second_o
);
    localparam int PTR_W = $clog2(NUM_LINES) + ibuf_pkg::HW_IDX_WIDTH;

    // ----------------------------------------
    // internal nets
    // ----------------------------------------
    logic [NUM_LINES-1:0]                            write_en;
    ibuf_pkg::line_t                                 write_line;
    ibuf_pkg::line_t [NUM_LINES-1:0]                 lines;
    logic [NUM_LINES-1:0]                            line_valid;
    logic [NUM_LINES-1:0][ibuf_pkg::HW_PER_LINE-1:0] full_len;
    // lines the pop pointer leaves this cycle
    logic [NUM_LINES-1:0]                            rel_lines;
    logic [PTR_W-1:0]                                pop_ptr;
    logic [ibuf_pkg::PC_WIDTH-1:0]                   pc;

    // fill from the icache
    ibuf_fill #(.NUM_LINES(NUM_LINES)) u_fill (
        .clk, .reset, .flush_i, .flush_pc_i,
        .fill_valid_i, .fill_data_i, .fill_excp_i, .fill_cause_i,
        .line_valid_i(line_valid),
        .write_en_o(write_en),
        .write_line_o(write_line),
        .fetch_req_o, .fetch_pc_o
    );

    // line storage
    for (genvar i = 0; i < NUM_LINES; i++) begin : g_line
        ibuf_line u_line (
            .clk, .reset, .flush_i,
            .write_en_i(write_en[i]),
            .write_line_i(write_line),
            .release_i(rel_lines[i]),
            .line_o(lines[i]),
            .valid_o(line_valid[i]),
            .full_len_o(full_len[i])
        );
    end

    // slots to decode
    ibuf_extract #(.NUM_LINES(NUM_LINES)) u_extract (
        .pop_ptr_i(pop_ptr), .pc_i(pc),
        .lines_i(lines), .valid_i(line_valid), .full_len_i(full_len),
        .slot_first_o, .slot_second_o
    );

    // issue and release
    ibuf_pop #(.NUM_LINES(NUM_LINES)) u_pop (
        .clk, .reset, .flush_i, .flush_pc_i, .single_rdy_i, .double_rdy_i,
        .slot_first_i(slot_first_o), .slot_second_i(slot_second_o),
        .pop_ptr_o(pop_ptr), .pc_o(pc), .release_o(rel_lines)
    );

endmodule

/* sim/ibuf_tb_util.svh */
// memory and exception model for the testbench; include inside a module, parcels are 2-byte aligned
`ifndef IBUF_TB_UTIL_SVH
`define IBUF_TB_UTIL_SVH

localparam logic [31:0] LFSR_SEED = 32'hb1f9;

// ----------------------------------------
// fibonacci lfsr, taps 32 22 2 1
// ----------------------------------------
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

// parcel at any address, the whole address seeds the lfsr
function automatic ibuf_pkg::halfword_t hw_at(input logic [31:0] addr);
    logic [31:0]         s;
    ibuf_pkg::halfword_t h;
    s = LFSR_SEED ^ (addr * 32'h9e3779b1);
    if (s == '0) begin
        s = LFSR_SEED;
    end
    for (int i = 0; i < 16; i++) begin
        s = lfsr_next(s);
        h[i] = s[0];
    end
    // about half the parcels start a 32-bit word
    s = lfsr_next(s);
    if (s[0]) begin
        h[1:0] = 2'b11;
    end else begin
        h[0] = 1'b0;
    end
    return h;
endfunction

// lines at offset 0x50 in each 256-byte block fault
function automatic logic line_excp(input logic [31:0] addr);
    return addr[7:4] == 4'b0101;
endfunction

// expected decode slot for an instruction starting at pc
function automatic ibuf_pkg::slot_t model_slot(input logic [31:0] pc);
    ibuf_pkg::slot_t     s;
    ibuf_pkg::halfword_t lo;
    ibuf_pkg::halfword_t hi;
    logic [31:0]         hi_pc;
    logic                e_lo;
    logic                e_hi;
    hi_pc = pc + 32'd2;
    lo = hw_at(pc);
    hi = hw_at(hi_pc);
    s.valid = 1'b1;
    s.pc = pc;
    s.is_rv = &lo[1:0];
    s.next_pc = pc + (s.is_rv ? 32'd4 : 32'd2);
    s.instr = s.is_rv ? {hi, lo} : {16'h0000, lo};
    e_lo = line_excp(pc);
    e_hi = s.is_rv & line_excp(hi_pc);
    s.excp = e_lo | e_hi;
    s.cause = e_lo ? pc[12:8] : hi_pc[12:8];
    return s;
endfunction

`endif

/* sim/ibuf_tb.sv */
// testbench for ibuf_top with two lines; stimulus is seeded and fully repeatable
module ibuf_tb;
    timeunit 1ns;
    timeprecision 1ps;

    `include "ibuf_tb_util.svh"

    localparam int NUM_LINES = 2;
    // six tests of about 400 cycles plus margin
    localparam int MAX_CYCLES = 4000;

    logic clk;
    logic reset;
    logic flush_i;
    logic [31:0] flush_pc_i;
    logic fill_valid_i;
    ibuf_pkg::halfword_t [ibuf_pkg::HW_PER_LINE-1:0] fill_data_i;
    logic fill_excp_i;
    logic [ibuf_pkg::CAUSE_WIDTH-1:0] fill_cause_i;
    logic single_rdy_i;
    logic double_rdy_i;
    logic fetch_req_o;
    logic [31:0] fetch_pc_o;
    ibuf_pkg::slot_t slot_first_o;
    ibuf_pkg::slot_t slot_second_o;

    // tb state
    logic [31:0] rng_state = LFSR_SEED;
    logic [31:0] exp_pc;
    ibuf_pkg::slot_t exp_first;
    ibuf_pkg::slot_t exp_second;
    logic [1:0] fill_delay;
    logic rdy_hold = 1'b0;
    logic drop_mode = 1'b0;
    logic hold_chk = 1'b0;
    int fills_accepted = 0;
    int issued = 0;
    int errors = 0;
    int tests = 0;
    int cycles = 0;
    string test_name = "reset";

    ibuf_top #(.NUM_LINES(NUM_LINES)) DUT (.*);

    always #50 clk = ~clk;

    function automatic logic take_bit();
        rng_state = lfsr_next(rng_state);
        return rng_state[0];
    endfunction

    // ----------------------------------------
    // fill and ready drivers
    // ----------------------------------------
    always @(posedge clk) begin
        ibuf_pkg::halfword_t [ibuf_pkg::HW_PER_LINE-1:0] ln;
        for (int i = 0; i < ibuf_pkg::HW_PER_LINE; i++) begin
            ln[i] = hw_at(fetch_pc_o + 32'(2 * i));
        end
        single_rdy_i <= rdy_hold ? 1'b0 : take_bit();
        double_rdy_i <= rdy_hold ? 1'b0 : take_bit();
        if (reset) begin
            fill_valid_i <= 1'b0;
            fill_delay <= '0;
        end else if (fill_valid_i) begin
            // flush drops a strobe in the same cycle
            if (fetch_req_o && !flush_i) begin
                fills_accepted++;
            end
            fill_valid_i <= 1'b0;
        end else if (fetch_req_o && !flush_i) begin
            if (fill_delay == 2'd0) begin
                fill_valid_i <= 1'b1;
                fill_data_i <= ln;
                fill_excp_i <= line_excp(fetch_pc_o);
                // fault-free lines carry a cause the buffer must not pick
                fill_cause_i <= line_excp(fetch_pc_o) ? fetch_pc_o[12:8] : ~fetch_pc_o[12:8];
                fill_delay <= {take_bit(), take_bit()};
            end else begin
                fill_delay <= fill_delay - 2'd1;
            end
        end else if (drop_mode && !fetch_req_o) begin
            // junk strobe the buffer has to ignore
            fill_valid_i <= 1'b1;
            fill_data_i <= ~ln;
            fill_excp_i <= 1'b1;
            fill_cause_i <= 5'h1f;
        end
    end

    // expected stream, advanced by the issue rule
    always_comb begin
        exp_first = model_slot(exp_pc);
        exp_second = model_slot(exp_first.next_pc);
    end

    always @(posedge clk) begin
        if (reset) begin
            exp_pc <= ibuf_pkg::RESET_PC;
        end else if (flush_i) begin
            exp_pc <= flush_pc_i;
        end else if (double_rdy_i && slot_second_o.valid) begin
            exp_pc <= exp_second.next_pc;
            issued += 2;
        end else if ((single_rdy_i || double_rdy_i) && slot_first_o.valid) begin
            exp_pc <= exp_first.next_pc;
            issued += 1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("run timed out after %0d cycles in test %s", cycles, test_name);
            $display("Checks failed");
            $finish;
        end
    end

    // ----------------------------------------
    // checks
    // ----------------------------------------
    a_first_pc: assert property (@(posedge clk) disable iff (reset)
        slot_first_o.valid |-> slot_first_o.pc == exp_first.pc)
    else begin
        errors++;
        $display("[FAIL] %s first pc expected %h actual %h", test_name,
                 $sampled(exp_first.pc), $sampled(slot_first_o.pc));
    end

    a_first_data: assert property (@(posedge clk) disable iff (reset)
        slot_first_o.valid |-> slot_first_o.instr == exp_first.instr
            && slot_first_o.is_rv == exp_first.is_rv
            && slot_first_o.next_pc == exp_first.next_pc)
    else begin
        errors++;
        $display("[FAIL] %s first instr expected %h actual %h", test_name,
                 $sampled(exp_first.instr), $sampled(slot_first_o.instr));
    end

    a_first_excp: assert property (@(posedge clk) disable iff (reset)
        slot_first_o.valid |-> slot_first_o.excp == exp_first.excp
            && (!exp_first.excp || slot_first_o.cause == exp_first.cause))
    else begin
        errors++;
        $display("[FAIL] %s first excp/cause expected %b/%h actual %b/%h", test_name,
                 $sampled(exp_first.excp), $sampled(exp_first.cause),
                 $sampled(slot_first_o.excp), $sampled(slot_first_o.cause));
    end

    a_second_data: assert property (@(posedge clk) disable iff (reset)
        slot_second_o.valid |-> slot_second_o.pc == exp_second.pc
            && slot_second_o.instr == exp_second.instr
            && slot_second_o.is_rv == exp_second.is_rv
            && slot_second_o.next_pc == exp_second.next_pc)
    else begin
        errors++;
        $display("[FAIL] %s second instr expected %h actual %h", test_name,
                 $sampled(exp_second.instr), $sampled(slot_second_o.instr));
    end

    a_second_excp: assert property (@(posedge clk) disable iff (reset)
        slot_second_o.valid |-> slot_second_o.excp == exp_second.excp
            && (!exp_second.excp || slot_second_o.cause == exp_second.cause))
    else begin
        errors++;
        $display("[FAIL] %s second excp/cause expected %b/%h actual %b/%h", test_name,
                 $sampled(exp_second.excp), $sampled(exp_second.cause),
                 $sampled(slot_second_o.excp), $sampled(slot_second_o.cause));
    end

    a_order: assert property (@(posedge clk) disable iff (reset)
        slot_second_o.valid |-> slot_first_o.valid)
    else begin
        errors++;
        $display("%s: second slot valid while the first slot is not", test_name);
    end

    a_flush_empty: assert property (@(posedge clk) disable iff (reset)
        flush_i |=> !slot_first_o.valid && !slot_second_o.valid)
    else begin
        errors++;
        $display("%s: slots still valid the cycle after a flush", test_name);
    end

    // flush_pc_i holds its value until the next flush
    a_flush_fetch: assert property (@(posedge clk) disable iff (reset)
        flush_i |=> fetch_pc_o == ($past(flush_pc_i) & ~32'hf))
    else begin
        errors++;
        $display("[FAIL] %s flush fetch pc expected %h actual %h", test_name,
                 $sampled(flush_pc_i) & ~32'hf, $sampled(fetch_pc_o));
    end

    a_hold: assert property (@(posedge clk) disable iff (reset)
        hold_chk |-> $stable(slot_first_o) && $stable(slot_second_o) && !fetch_req_o)
    else begin
        errors++;
        $display("%s: slots changed or fetch request rose under back-pressure", test_name);
    end

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    task automatic flush_to(input logic [31:0] pc);
        @(posedge clk);
        flush_i <= 1'b1;
        flush_pc_i <= pc;
        @(posedge clk);
        flush_i <= 1'b0;
    endtask

    task automatic finish_test(input int err_base, input int issue_base);
        tests++;
        if (issue_base >= 0) begin
            assert (issued > issue_base) else begin
                errors++;
                $display("%s: no instruction was issued", test_name);
            end
        end
        $display("test %s done, %0d errors", test_name, errors - err_base);
    endtask

    task automatic stream_test(input string name, input logic [31:0] pc, input bit do_flush);
        int e0;
        int i0;
        test_name = name;
        e0 = errors;
        i0 = issued;
        if (do_flush) begin
            flush_to(pc);
        end
        repeat (300) @(posedge clk);
        finish_test(e0, i0);
    endtask

    initial begin
        int e0;
        int f0;
        int i0;
        clk = 1'b0;
        reset = 1'b1;
        flush_i = 1'b0;
        flush_pc_i = '0;
        fill_valid_i = 1'b0;
        fill_data_i = '0;
        fill_excp_i = 1'b0;
        fill_cause_i = '0;
        single_rdy_i = 1'b0;
        double_rdy_i = 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        // state straight out of reset
        e0 = errors;
        @(posedge clk);
        assert (!slot_first_o.valid && !slot_second_o.valid && fetch_req_o
                && fetch_pc_o == ibuf_pkg::RESET_PC) else begin
            errors++;
            $display("[FAIL] reset fetch_pc expected %h actual %h, or a bad valid/request",
                     ibuf_pkg::RESET_PC, fetch_pc_o);
        end
        finish_test(e0, -1);

        stream_test("content", 32'h0, 1'b0);
        stream_test("order", 32'h0000_1002, 1'b1);
        stream_test("exceptions", 32'h0000_0040, 1'b1);

        // readies low until full, then junk strobes while held
        test_name = "backpressure";
        e0 = errors;
        i0 = issued;
        rdy_hold <= 1'b1;
        flush_to(32'h0000_0300);
        f0 = fills_accepted;
        while (fills_accepted - f0 < NUM_LINES) @(posedge clk);
        @(posedge clk);
        assert (!fetch_req_o) else begin
            errors++;
            $display("backpressure: fetch request still high with all lines filled");
        end
        drop_mode <= 1'b1;
        hold_chk <= 1'b1;
        repeat (20) @(posedge clk);
        hold_chk <= 1'b0;
        drop_mode <= 1'b0;
        @(posedge clk);
        rdy_hold <= 1'b0;
        repeat (200) @(posedge clk);
        finish_test(e0, i0);

        stream_test("flush", 32'h0000_0256, 1'b1);

        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+sim
rtl/ibuf_pkg.sv
rtl/ibuf_fill.sv
rtl/ibuf_line.sv
rtl/ibuf_extract.sv
rtl/ibuf_pop.sv
rtl/ibuf_top.sv
sim/ibuf_tb.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --assert --top-module ibuf_tb -f build.f -o ibuf_sim > sim.log 2>&1 &&
./obj_dir/ibuf_sim >> sim.log 2>&1
cat sim.log
grep -qx "All checks passed" sim.log && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}
